/* Makefile */
SIM      = verilator
TOP      = lvda_tb
FILELIST = lvda.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+1000
LOG      = sim.log
PASS_MSG = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* lvda.f */
src/lvda_pkg.sv
src/io_decode.sv
src/cmd_sequencer.sv
src/countdown.sv
src/processor_store.sv
src/lvda.sv
verif/lvda_properties.sv
verif/lvda_tb.sv

/* src/cmd_sequencer.sv */
`timescale 1ns/1ns

module cmd_sequencer (
    input  logic             sim_clk,
    input  logic             arst_n,
    input  logic             pio,
    input  logic             accept,
    output lvda_pkg::phase_t phase,
    output logic             sample,
    output logic             exec,
    output logic             done
);

    import lvda_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       sample_nxt;

    // Word slot timing, one phase per clock
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= PH_W;
        end else begin
            phase <= phase_t'(phase + 2'd1);
        end
    end

    // Request is seen in phase Z so that sample lands on the next phase W
    assign sample_nxt = (state == S_IDLE) && pio && (phase == PH_Z);

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            sample <= 1'b0;
        end else begin
            sample <= sample_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (sample) begin
                    state_nxt = S_WAIT;
                end
            end
            S_WAIT: begin
                // Decode result is first valid in phase X
                if (phase == PH_X && !accept) begin
                    state_nxt = S_HOLD;
                end else if (phase == PH_W) begin
                    state_nxt = S_EXEC;
                end
            end
            S_EXEC: begin
                if (phase == PH_Z) begin
                    state_nxt = pio ? S_HOLD : S_IDLE;
                end
            end
            S_HOLD: begin
                if (!pio) begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Command executes in Y and replies in Z of the second slot
    assign exec = (state == S_EXEC) && (phase == PH_Y);
    assign done = (state == S_EXEC) && (phase == PH_Z);

endmodule

/* src/countdown.sv */
`timescale 1ns/1ns

module countdown (
    input  logic              sim_clk,
    input  logic              arst_n,
    input  lvda_pkg::phase_t  phase,
    input  logic              exec,
    input  lvda_pkg::opcode_t op,
    input  lvda_pkg::data_t   c2,
    output lvda_pkg::data_t   count,
    output logic              its
);

    import lvda_pkg::*;

    logic running;
    logic load;
    logic ack;
    logic tick;
    logic last_tick;

    assign load      = exec && (op == OP_START_COUNT);
    assign ack       = exec && (op == OP_ACK_INT);
    assign tick      = running && (phase == PH_Z); // Once per word slot
    assign last_tick = tick && (count == data_t'(1));

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (load) begin
            count   <= c2;
            running <= (c2 != '0);
        end else if (tick) begin
            count <= count - data_t'(1);
            if (last_tick) begin
                running <= 1'b0;
            end
        end
    end

    // Interrupt stays up until the computer acknowledges it
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            its <= 1'b0;
        end else if (load && c2 == '0) begin
            its <= 1'b1; // Zero reload expires at once
        end else if (ack) begin
            its <= 1'b0;
        end else if (last_tick) begin
            its <= 1'b1;
        end
    end

endmodule

/* src/io_decode.sv */
`timescale 1ns/1ns

module io_decode (
    input  logic              sim_clk,
    input  logic              arst_n,
    input  logic              sample,
    input  lvda_pkg::addr_t   addr,
    output lvda_pkg::opcode_t op,
    output logic              accept,
    output logic              err
);

    import lvda_pkg::*;

    logic [SEL_W-1:0] sel_field;
    logic [OP_W-1:0]  op_field;
    logic             parity_ok;
    logic             op_valid;
    logic             bad_cmd;

    assign sel_field = addr[SEL_W-1:0];
    assign op_field  = addr[SEL_W +: OP_W];

    // All nine bits together must carry an odd number of ones
    assign parity_ok = ^addr;

    always_comb begin
        case (op_field)
            OP_WRITE_C2,
            OP_WRITE_C3,
            OP_START_COUNT,
            OP_ACK_INT,
            OP_READ_C3,
            OP_READ_COUNT: op_valid = 1'b1;
            default:       op_valid = 1'b0;
        endcase
    end

    assign bad_cmd = !parity_ok || !op_valid;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            accept <= 1'b0;
            err    <= 1'b0;
        end else if (sample) begin
            accept <= (sel_field == LVDA_ID); // Other modules on the bus ignore this word
            err    <= bad_cmd;
        end
    end

    // A rejected command leaves a code that no register reacts to
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            op <= opcode_t'(OP_IGNORE);
        end else if (sample) begin
            if (bad_cmd) begin
                op <= opcode_t'(OP_IGNORE);
            end else begin
                op <= opcode_t'(op_field);
            end
        end
    end

endmodule

/* src/lvda.sv */
`timescale 1ns/1ns

module lvda (
    input  logic            sim_clk,
    input  logic            arst_n,
    input  logic            pio,
    input  lvda_pkg::addr_t addr,
    input  lvda_pkg::data_t data_in,
    output logic            done,
    output logic            err,
    output lvda_pkg::data_t data_out,
    output logic            its
);

    import lvda_pkg::*;

    phase_t  phase;
    logic    sample;
    logic    exec;
    logic    accept;
    logic    dec_err;
    opcode_t op;
    data_t   count;
    data_t   c2;

    cmd_sequencer cmd_sequencer_i (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .pio     (pio),
        .accept  (accept),
        .phase   (phase),
        .sample  (sample),
        .exec    (exec),
        .done    (done)
    );

    io_decode io_decode_i (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .sample  (sample),
        .addr    (addr),
        .op      (op),
        .accept  (accept),
        .err     (dec_err)
    );

    countdown countdown_i (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .phase   (phase),
        .exec    (exec),
        .op      (op),
        .c2      (c2),
        .count   (count),
        .its     (its)
    );

    processor_store processor_store_i (
        .sim_clk  (sim_clk),
        .arst_n   (arst_n),
        .exec     (exec),
        .op       (op),
        .data_in  (data_in),
        .count    (count),
        .c2       (c2),
        .data_out (data_out)
    );

    assign err = done & dec_err; // Error status only means something alongside done

endmodule

/* src/lvda_pkg.sv */
package lvda_pkg;

    // Address word is parity, opcode, module select from msb to lsb
    localparam int ADDR_W = 9;
    localparam int DATA_W = 8;
    localparam int OP_W   = 4;
    localparam int SEL_W  = 4;

    // Module select this adapter answers to
    localparam logic [SEL_W-1:0] LVDA_ID = 4'd5;

    // Opcode that no block acts on, used after a failed check
    localparam logic [OP_W-1:0] OP_IGNORE = '1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    typedef enum logic [OP_W-1:0] {
        OP_WRITE_C2    = 4'd0,
        OP_WRITE_C3    = 4'd1,
        OP_START_COUNT = 4'd2,
        OP_ACK_INT     = 4'd3,
        OP_READ_C3     = 4'd4,
        OP_READ_COUNT  = 4'd5
    } opcode_t;

    typedef enum logic [1:0] {
        PH_W,
        PH_X,
        PH_Y,
        PH_Z
    } phase_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_EXEC,
        S_HOLD
    } seq_state_t;

endpackage

/* src/processor_store.sv */
`timescale 1ns/1ns

module processor_store (
    input  logic              sim_clk,
    input  logic              arst_n,
    input  logic              exec,
    input  lvda_pkg::opcode_t op,
    input  lvda_pkg::data_t   data_in,
    input  lvda_pkg::data_t   count,
    output lvda_pkg::data_t   c2,
    output lvda_pkg::data_t   data_out
);

    import lvda_pkg::*;

    data_t c3;

    // C2 doubles as the countdown reload value
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            c2 <= '0;
            c3 <= '0;
        end else if (exec) begin
            case (op)
                OP_WRITE_C2: c2 <= data_in;
                OP_WRITE_C3: c3 <= data_in;
                default: begin
                    c2 <= c2;
                    c3 <= c3;
                end
            endcase
        end
    end

    // Read-back word is held for the computer until the next read
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
        end else if (exec) begin
            case (op)
                OP_READ_C3:    data_out <= c3;
                OP_READ_COUNT: data_out <= count; // Live value while the countdown runs
                default:       data_out <= data_out;
            endcase
        end
    end

endmodule

/* verif/lvda_properties.sv */
`timescale 1ns/1ns

module lvda_properties (
    input logic              sim_clk,
    input logic              arst_n,
    input logic              sample,
    input logic              accept,
    input logic              exec,
    input lvda_pkg::opcode_t op,
    input logic              done,
    input logic              err,
    input logic              its
);

    import lvda_pkg::*;

    int unsigned assert_fails;

    initial assert_fails = 0;

    done_single: assert property (@(posedge sim_clk) disable iff (!arst_n)
        done |=> !done)
        else begin
            assert_fails++;
            $error("done stayed high for two cycles");
        end

    err_only_with_done: assert property (@(posedge sim_clk) disable iff (!arst_n)
        !done |-> !err)
        else begin
            assert_fails++;
            $error("err high without done");
        end

    // The interrupt is sticky until the computer acknowledges it
    its_held: assert property (@(posedge sim_clk) disable iff (!arst_n)
        $fell(its) |-> $past(exec && (op == OP_ACK_INT)))
        else begin
            assert_fails++;
            $error("its fell without an acknowledge command");
        end

    done_after_sample: assert property (@(posedge sim_clk) disable iff (!arst_n)
        ($past(sample, 7) && $past(accept, 6)) |-> done)
        else begin
            assert_fails++;
            $error("no done seven cycles after an accepted sample");
        end

    done_has_sample: assert property (@(posedge sim_clk) disable iff (!arst_n)
        done |-> ($past(sample, 7) && $past(accept, 6)))
        else begin
            assert_fails++;
            $error("done without an accepted sample seven cycles before");
        end

endmodule

/* verif/lvda_tb.sv */
`timescale 1ns/1ns

module lvda_tb;

    import lvda_pkg::*;

    logic        sim_clk;
    logic        arst_n;
    logic        pio;
    addr_t       addr;
    data_t       data_in;
    logic        done;
    logic        err;
    data_t       data_out;
    logic        its;

    data_t       model_c2;
    data_t       model_c3;
    bit          exp_err;
    int          read_mode; // 0 no check, 1 exact value, 2 upper bound
    data_t       exp_data;
    time         done_time;
    time         its_rise_time;
    int          errors;
    int          test_num;
    int          test_err_base;
    int          failed_tests;

    lvda lvda_i (
        .sim_clk  (sim_clk),
        .arst_n   (arst_n),
        .pio      (pio),
        .addr     (addr),
        .data_in  (data_in),
        .done     (done),
        .err      (err),
        .data_out (data_out),
        .its      (its)
    );

    bind lvda lvda_properties lvda_properties_i (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .sample  (sample),
        .accept  (accept),
        .exec    (exec),
        .op      (op),
        .done    (done),
        .err     (err),
        .its     (its)
    );

    always #4 sim_clk = ~sim_clk;

    always @(posedge its) its_rise_time = $time;

    err_at_done: assert property (@(posedge sim_clk) disable iff (!arst_n)
        done |-> (err == exp_err))
        else begin
            $display("** Error @ %0t: err is %0b at done, expected %0b",
                     $time, $sampled(err), $sampled(exp_err));
            errors++;
        end

    read_exact: assert property (@(posedge sim_clk) disable iff (!arst_n)
        (done && read_mode == 1) |-> (data_out == exp_data))
        else begin
            $display("** Error @ %0t: data_out is %0h, expected %0h",
                     $time, $sampled(data_out), $sampled(exp_data));
            errors++;
        end

    // A running count can only have moved down from its reload value
    read_bound: assert property (@(posedge sim_clk) disable iff (!arst_n)
        (done && read_mode == 2) |-> (data_out <= exp_data))
        else begin
            $display("** Error @ %0t: count read %0d, above the reload %0d",
                     $time, $sampled(data_out), $sampled(exp_data));
            errors++;
        end

    task automatic expect_bit(input logic actual, input logic expected, input string what);
        assert (actual === expected) else begin
            $display("** Error @ %0t: %s is %0b, expected %0b", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int n_err;
        n_err = errors - test_err_base;
        test_num++;
        if (n_err == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, n_err);
            failed_tests++;
        end
        test_err_base = errors;
    endtask

    task automatic issue_cmd(input logic [3:0] opc, input logic [3:0] sel, input data_t wdata,
                             input bit bad_par, input bit want_done);
        logic [7:0] low;
        logic       par;
        int         i;
        bit         seen;
        low = {opc, sel};
        par = ~(^low); // Nine bits with odd parity
        if (bad_par) begin
            par = ~par;
        end
        exp_err   = bad_par || (opc > 4'd5);
        read_mode = 0;
        if (!exp_err && opc == OP_READ_C3) begin
            read_mode = 1;
            exp_data  = model_c3;
        end else if (!exp_err && opc == OP_READ_COUNT) begin
            read_mode = 2;
            exp_data  = model_c2;
        end
        @(posedge sim_clk);
        #1;
        addr    = {par, low};
        data_in = wdata;
        pio     = 1'b1;
        seen    = 1'b0;
        for (i = 0; i < (want_done ? 20 : 16) && !seen; i++) begin
            @(negedge sim_clk);
            if (done) begin
                seen      = 1'b1;
                done_time = $time;
            end
        end
        @(posedge sim_clk);
        #1;
        pio = 1'b0;
        if (want_done) begin
            assert (seen) else begin
                $display("timeout: no done within 20 cycles for opcode %0h", opc);
                errors++;
            end
        end else begin
            assert (!seen) else begin
                $display("** Error @ %0t: done for foreign module select %0h", $time, sel);
                errors++;
            end
        end
        if (seen && !exp_err) begin
            if (opc == OP_WRITE_C2) begin
                model_c2 = wdata;
            end
            if (opc == OP_WRITE_C3) begin
                model_c3 = wdata;
            end
        end
    endtask

    initial begin
        data_t      v;
        logic [3:0] bad_op;
        logic [3:0] other_sel;
        int         n;
        int         i;
        int         cycles;
        time        start_done;
        int         prop_fails;
        sim_clk       = 1'b0;
        arst_n        = 1'b0;
        pio           = 1'b0;
        addr          = '0;
        data_in       = '0;
        model_c2      = '0;
        model_c3      = '0;
        exp_err       = 1'b0;
        read_mode     = 0;
        exp_data      = '0;
        done_time     = 0;
        its_rise_time = 0;
        errors        = 0;
        test_num      = 0;
        test_err_base = 0;
        failed_tests  = 0;
        void'($urandom(32'h50ef));
        repeat (8) @(posedge sim_clk);
        #1;
        arst_n = 1'b1;
        @(negedge sim_clk);

        expect_bit(done, 1'b0, "done");
        expect_bit(err, 1'b0, "err");
        expect_bit(its, 1'b0, "its");
        assert (data_out == '0) else begin
            $display("** Error @ %0t: data_out is %0h after reset", $time, data_out);
            errors++;
        end
        finish_test("reset values");

        repeat (4) begin
            v = data_t'($urandom);
            issue_cmd(OP_WRITE_C3, LVDA_ID, v, 1'b0, 1'b1);
            issue_cmd(OP_READ_C3, LVDA_ID, '0, 1'b0, 1'b1);
        end
        finish_test("c3 write and read back");

        issue_cmd(OP_WRITE_C3, LVDA_ID, data_t'($urandom), 1'b1, 1'b1);
        bad_op = 4'(6 + $urandom % 10);
        issue_cmd(bad_op, LVDA_ID, data_t'($urandom), 1'b0, 1'b1);
        issue_cmd(OP_READ_C3, LVDA_ID, '0, 1'b0, 1'b1);
        finish_test("parity and opcode errors");

        other_sel = LVDA_ID + 4'(1 + $urandom % 15);
        issue_cmd(OP_WRITE_C3, other_sel, data_t'($urandom), 1'b0, 1'b0);
        issue_cmd(OP_READ_C3, LVDA_ID, '0, 1'b0, 1'b1);
        finish_test("foreign module select");

        repeat (2) begin
            n = 1 + int'($urandom % 20);
            issue_cmd(OP_WRITE_C2, LVDA_ID, data_t'(n), 1'b0, 1'b1);
            its_rise_time = 0;
            issue_cmd(OP_START_COUNT, LVDA_ID, '0, 1'b0, 1'b1);
            start_done = done_time;
            issue_cmd(OP_READ_COUNT, LVDA_ID, '0, 1'b0, 1'b1);
            for (i = 0; i < 4 * n + 16 && its !== 1'b1; i++) begin
                @(negedge sim_clk);
            end
            if (its !== 1'b1) begin
                $display("timeout: its did not rise for a countdown from %0d", n);
                errors++;
            end else begin
                cycles = int'((its_rise_time - start_done) / 8);
                assert (cycles >= 4 * (n - 1) && cycles <= 4 * n + 8) else begin
                    $display("** Error @ %0t: its rose %0d cycles after start, count %0d",
                             $time, cycles, n);
                    errors++;
                end
            end
            issue_cmd(OP_ACK_INT, LVDA_ID, '0, 1'b0, 1'b1);
            expect_bit(its, 1'b0, "its after acknowledge");
        end
        finish_test("interrupt countdown");

        issue_cmd(OP_WRITE_C2, LVDA_ID, '0, 1'b0, 1'b1);
        issue_cmd(OP_START_COUNT, LVDA_ID, '0, 1'b0, 1'b1);
        expect_bit(its, 1'b1, "its after zero reload");
        issue_cmd(OP_ACK_INT, LVDA_ID, '0, 1'b0, 1'b1);
        expect_bit(its, 1'b0, "its after acknowledge");
        finish_test("acknowledge and zero reload");

        prop_fails = int'(lvda_i.lvda_properties_i.assert_fails);
        $display("tests %0d, failed tests %0d, check errors %0d, property failures %0d",
                 test_num, failed_tests, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
